// ==== mbox_bridge.f ====
common/mbox_pkg.sv
hdl/req_fifo.sv
hdl/stream_assembler.sv
mbox/mbox_ctrl.sv
mbox/mbox_regs.sv
hdl/mbox_bridge.sv
+incdir+verif
verif/tb_mbox_bridge.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the mailbox bridge

VERILATOR ?= verilator
TOP       ?= tb_mbox_bridge
RTL_TOP   ?= mbox_bridge
FILELIST  ?= mbox_bridge.f
SEED      ?= df2ce152
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=32\'h$(SEED) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/mbox_model.svh ====
// Register file reference model
`ifndef MBOX_MODEL_SVH
`define MBOX_MODEL_SVH

// eight mailbox words plus the two attention bits
logic [DATA_W-1:0] exp_mb [MB_NUM];
logic              exp_en;
logic              exp_sts;
int                exp_irq_cnt;

function automatic void clear_model();
    for (int i = 0; i < MB_NUM; i++) begin
        exp_mb[i] = '0;
    end
    exp_en      = 1'b0;
    exp_sts     = 1'b0;
    exp_irq_cnt = 0;
endfunction

function automatic void apply_local_write(input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] data);
    if (addr >= MB_LOW && addr <= MB_HIGH) begin
        exp_mb[MB_IDX_W'((addr - MB_LOW) / 4)] = data;
    end else if (addr >= AA_LOW && addr <= AA_HIGH) begin
        if ((addr - AA_LOW) / 4 == 0) begin
            exp_en = data[0];
        end else if (data[0]) begin
            // status clears on a written one
            exp_sts = 1'b0;
        end
    end
endfunction

function automatic void apply_remote_write(input logic [RMT_ADDR_W-1:0] addr,
                                           input logic [DATA_W-1:0]     data);
    if (addr >= RMT_ADDR_W'(MB_LOW) && addr <= RMT_ADDR_W'(MB_HIGH)) begin
        exp_mb[MB_IDX_W'((addr - RMT_ADDR_W'(MB_LOW)) / 4)] = data;
        if (exp_en) begin
            exp_sts     = 1'b1;
            exp_irq_cnt = exp_irq_cnt + 1;
        end
    end
endfunction

function automatic logic [DATA_W-1:0] predict_read(input logic [ADDR_W-1:0] addr);
    if (addr >= MB_LOW && addr <= MB_HIGH) begin
        return exp_mb[MB_IDX_W'((addr - MB_LOW) / 4)];
    end
    if (addr >= AA_LOW && addr <= AA_HIGH) begin
        // only bit 0 of each attention word exists
        return ((addr - AA_LOW) / 4 == 0) ? DATA_W'(exp_en) : DATA_W'(exp_sts);
    end
    return '1;
endfunction

`endif

// ==== verif/tb_mbox_bridge.sv ====
// Mailbox bridge testbench
`timescale 1ns/10ps

module tb_mbox_bridge
    import mbox_pkg::*;
#(
    parameter logic [31:0] SEED = 32'hdf2ce152
);

    localparam int FIFO_DEPTH = 8;
    localparam int N_WR       = 12;
    localparam int POLL_MAX   = 16;
    localparam int SYNC_TXN   = 2 + POLL_MAX;
    // transactions per test, 64 cycles each
    localparam int TXN_TOTAL  = 10 + (N_WR + 10) + (2 * N_WR + 10)
                              + (9 * (N_WR / 2) + SYNC_TXN + 10)
                              + (48 + 2 * SYNC_TXN + 20)
                              + (3 * N_WR + SYNC_TXN + 12);
    localparam int CYCLE_LIMIT = 64 * TXN_TOTAL;

    logic              axi_aclk;
    logic              axi_aresetn;
    logic              bk_ls_wstart;
    logic [ADDR_W-1:0] bk_ls_waddr;
    logic [DATA_W-1:0] bk_ls_wdata;
    logic              bk_ls_rstart;
    logic [ADDR_W-1:0] bk_ls_raddr;
    logic              bk_ls_ready;
    logic [DATA_W-1:0] bk_ls_rdata;
    logic              bk_ls_rdone;
    logic [DATA_W-1:0] bk_ss_data;
    logic [1:0]        bk_ss_user;
    logic              bk_ss_valid;
    logic              bk_ss_ready;
    logic              axi_interrupt;

    int cycle_cnt;
    int checks;
    int errors;
    int test_num;
    int test_checks;
    int test_errors;
    int irq_seen;
    int stall_cycles;
    int sync_tag;

    `include "mbox_model.svh"

    mbox_bridge #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .bk_ls_wstart  (bk_ls_wstart),
        .bk_ls_waddr   (bk_ls_waddr),
        .bk_ls_wdata   (bk_ls_wdata),
        .bk_ls_rstart  (bk_ls_rstart),
        .bk_ls_raddr   (bk_ls_raddr),
        .bk_ls_ready   (bk_ls_ready),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ls_rdone   (bk_ls_rdone),
        .bk_ss_data    (bk_ss_data),
        .bk_ss_user    (bk_ss_user),
        .bk_ss_valid   (bk_ss_valid),
        .bk_ss_ready   (bk_ss_ready),
        .axi_interrupt (axi_interrupt)
    );

    initial begin
        axi_aclk = 1'b0;
        forever #10 axi_aclk = ~axi_aclk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge axi_aclk);
            cycle_cnt++;
        end
        $display("run stopped by the cycle limit after %0d cycles", cycle_cnt);
        $display("RESULT: FAIL");
        $finish;
    end

    // outputs are stable at the falling edge
    always @(negedge axi_aclk) begin
        if (axi_aresetn && axi_interrupt) begin
            irq_seen++;
        end
    end

    // ------------------------------------------------------------
    // checks and report
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        test_checks++;
        assert (cond) else begin
            $display("Error t=%0t %s", $time, what);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %-12s %0d checks, %0d errors", test_num, name, test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // local requester
    // ------------------------------------------------------------
    task automatic local_start(input logic wr, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data);
        @(negedge axi_aclk);
        while (!bk_ls_ready) begin
            @(negedge axi_aclk);
        end
        @(posedge axi_aclk);
        if (wr) begin
            bk_ls_wstart <= 1'b1;
            bk_ls_waddr  <= addr;
            bk_ls_wdata  <= data;
        end else begin
            bk_ls_rstart <= 1'b1;
            bk_ls_raddr  <= addr;
        end
        @(posedge axi_aclk);
        bk_ls_wstart <= 1'b0;
        bk_ls_rstart <= 1'b0;
    endtask

    task automatic local_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        local_start(1'b1, addr, data);
        apply_local_write(addr, data);
    endtask

    task automatic local_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int waited;
        local_start(1'b0, addr, '0);
        waited = 0;
        @(negedge axi_aclk);
        while (!bk_ls_rdone && waited < 64 * (FIFO_DEPTH + 2)) begin
            @(negedge axi_aclk);
            waited++;
        end
        check_true(bk_ls_rdone, $sformatf("read of %h got no bk_ls_rdone", addr));
        data = bk_ls_rdata;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] got;
        local_read(addr, got);
        check_value($sformatf("bk_ls_rdata[%h]", addr), predict_read(addr), got);
    endtask

    task automatic read_all();
        for (int i = 0; i < MB_NUM; i++) begin
            read_check(MB_LOW + ADDR_W'(4 * i));
        end
        read_check(AA_LOW);
        read_check(AA_LOW + 15'h4);
    endtask

    function automatic logic [ADDR_W-1:0] unsupp_addr(input bit in_window);
        if (in_window) begin
            return ADDR_W'($urandom_range(32'h2108, 32'h2FFF)) & ~15'h3;
        end
        if ($urandom_range(0, 1) != 0) begin
            return ADDR_W'($urandom_range(32'h3000, 32'h7FFF));
        end
        return ADDR_W'($urandom_range(0, 32'h1FFF));
    endfunction

    // ------------------------------------------------------------
    // remote stream source
    // ------------------------------------------------------------
    // entered right after a rising edge, leaves after the transfer edge
    task automatic send_beat(input logic [DATA_W-1:0] data, input logic [1:0] user);
        bk_ss_data  <= data;
        bk_ss_user  <= user;
        bk_ss_valid <= 1'b1;
        @(negedge axi_aclk);
        while (!bk_ss_ready) begin
            stall_cycles++;
            @(negedge axi_aclk);
        end
        @(posedge axi_aclk);
    endtask

    task automatic send_junk(input int n);
        logic [1:0] user;
        repeat (n) begin
            // any tuser code but the write
            user = 2'($urandom_range(0, 2));
            if (user == 2'b01) begin
                user = 2'b11;
            end
            send_beat($urandom, user);
        end
    endtask

    task automatic remote_write(input logic [RMT_ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data, input int max_junk);
        send_beat({4'($urandom), addr}, 2'b01);
        send_junk($urandom_range(0, max_junk));
        send_beat(data, 2'b01);
        apply_remote_write(addr, data);
    endtask

    task automatic remote_traffic(input int n, input int lo, input int hi,
                                  input int max_junk, input int n_bad);
        logic [RMT_ADDR_W-1:0] bad;
        @(posedge axi_aclk);
        for (int i = 0; i < n; i++) begin
            send_junk($urandom_range(0, max_junk));
            if (i < n_bad) begin
                bad = (i == 0) ? RMT_ADDR_W'(AA_LOW) : RMT_ADDR_W'($urandom);
                if (bad >= RMT_ADDR_W'(MB_LOW) && bad <= RMT_ADDR_W'(MB_HIGH)) begin
                    bad = bad ^ RMT_ADDR_W'(12'h100);
                end
                remote_write(bad, $urandom, max_junk);
            end
            remote_write(RMT_ADDR_W'(MB_LOW) + RMT_ADDR_W'(4 * $urandom_range(lo, hi)),
                         $urandom, max_junk);
        end
        bk_ss_valid <= 1'b0;
    endtask

    // tagged write to word 7 marks the end of the stream
    task automatic sync_remote();
        logic [DATA_W-1:0] tag;
        logic [DATA_W-1:0] got;
        int polls;
        sync_tag++;
        tag = 32'h5A5A_0000 + DATA_W'(sync_tag);
        @(posedge axi_aclk);
        remote_write(RMT_ADDR_W'(MB_LOW) + 28'h1C, tag, 0);
        bk_ss_valid <= 1'b0;
        polls = 0;
        got   = '0;
        while (got !== tag && polls < POLL_MAX) begin
            local_read(MB_LOW + 15'h1C, got);
            polls++;
        end
        check_true(got === tag, "remote stream did not drain within the poll limit");
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        logic [ADDR_W-1:0] addr;
        void'($urandom(SEED));
        axi_aresetn  = 1'b0;
        bk_ls_wstart = 1'b0;
        bk_ls_waddr  = '0;
        bk_ls_wdata  = '0;
        bk_ls_rstart = 1'b0;
        bk_ls_raddr  = '0;
        bk_ss_data   = '0;
        bk_ss_user   = '0;
        bk_ss_valid  = 1'b0;
        checks = 0;
        errors = 0;
        test_num = 0;
        test_checks = 0;
        test_errors = 0;
        irq_seen = 0;
        stall_cycles = 0;
        sync_tag = 0;
        clear_model();
        repeat (2) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;

        @(negedge axi_aclk);
        check_value("bk_ls_ready", 32'd1, DATA_W'(bk_ls_ready));
        check_value("bk_ss_ready", 32'd1, DATA_W'(bk_ss_ready));
        check_value("bk_ls_rdone", 32'd0, DATA_W'(bk_ls_rdone));
        check_value("axi_interrupt", 32'd0, DATA_W'(axi_interrupt));
        read_all();
        end_test("reset");

        for (int i = 0; i < N_WR; i++) begin
            local_write(MB_LOW + ADDR_W'(4 * $urandom_range(0, MB_NUM - 1)), $urandom);
        end
        read_all();
        end_test("mailbox");

        for (int i = 0; i < N_WR; i++) begin
            addr = unsupp_addr(i % 2 == 0);
            read_check(addr);
            local_write(addr, $urandom);
        end
        read_all();
        end_test("unsupported");

        // remote uses words 4 to 7, local uses 0 to 3
        fork
            remote_traffic(N_WR / 2, 4, 6, 2, 3);
            begin
                for (int i = 0; i < N_WR / 2; i++) begin
                    local_write(MB_LOW + ADDR_W'(4 * $urandom_range(0, 3)), $urandom);
                end
            end
        join
        sync_remote();
        read_all();
        check_value("axi_interrupt pulses", DATA_W'(exp_irq_cnt), DATA_W'(irq_seen));
        end_test("remote");

        local_write(AA_LOW, 32'hFFFF_FFFF);
        read_check(AA_LOW);
        remote_traffic(3, 4, 6, 1, 0);
        sync_remote();
        check_value("axi_interrupt pulses", DATA_W'(exp_irq_cnt), DATA_W'(irq_seen));
        read_check(AA_LOW + 15'h4);
        // bit 0 clear leaves the status alone
        local_write(AA_LOW + 15'h4, 32'hFFFF_FFFE);
        local_write(AA_LOW, '0);
        read_check(AA_LOW);
        remote_traffic(3, 4, 6, 1, 0);
        sync_remote();
        check_value("axi_interrupt pulses", DATA_W'(exp_irq_cnt), DATA_W'(irq_seen));
        read_check(AA_LOW + 15'h4);
        local_write(AA_LOW + 15'h4, 32'h1);
        read_all();
        end_test("interrupt");

        // one pulse per completed remote write shows that no write went missing
        local_write(AA_LOW, 32'h1);
        read_check(AA_LOW);
        stall_cycles = 0;
        fork
            remote_traffic(N_WR, 4, 6, 0, 0);
            begin
                for (int i = 0; i < N_WR; i++) begin
                    read_check(MB_LOW + ADDR_W'(4 * (i % 4)));
                end
            end
        join
        sync_remote();
        check_true(stall_cycles > 0, "bk_ss_ready never dropped during the burst");
        read_all();
        check_value("axi_interrupt pulses", DATA_W'(exp_irq_cnt), DATA_W'(irq_seen));
        end_test("backpressure");

        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/mbox_bridge.sv ====
// Mailbox register bridge top
`timescale 1ns/10ps

module mbox_bridge
    import mbox_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  logic              bk_ls_wstart,
    input  logic [ADDR_W-1:0] bk_ls_waddr,
    input  logic [DATA_W-1:0] bk_ls_wdata,
    input  logic              bk_ls_rstart,
    input  logic [ADDR_W-1:0] bk_ls_raddr,
    output logic              bk_ls_ready,
    output logic [DATA_W-1:0] bk_ls_rdata,
    output logic              bk_ls_rdone,
    input  logic [DATA_W-1:0] bk_ss_data,
    input  logic [1:0]        bk_ss_user,
    input  logic              bk_ss_valid,
    output logic              bk_ss_ready,
    output logic              axi_interrupt
);

    ls_req_t           ls_in;
    ls_req_t           ls_head;
    logic              ls_valid;
    logic              ls_pop;
    rmt_beat_t         ss_in;
    rmt_beat_t         ss_head;
    logic              ss_valid;
    logic              ss_pop;
    logic              rmt_valid;
    logic              rmt_take;
    rmt_wr_t           rmt;
    logic              reg_cmd_valid;
    reg_cmd_t          reg_cmd;
    logic [DATA_W-1:0] rd_data;
    logic              irq_req;

    // write wins when both start pulses are high
    assign ls_in.op    = bk_ls_wstart ? LS_WR : LS_RD;
    assign ls_in.addr  = bk_ls_wstart ? bk_ls_waddr : bk_ls_raddr;
    assign ls_in.wdata = bk_ls_wstart ? bk_ls_wdata : '0;

    assign ss_in.data = bk_ss_data;
    assign ss_in.user = bk_ss_user;

    req_fifo #(.WIDTH($bits(ls_req_t)), .FIFO_DEPTH(FIFO_DEPTH)) fifo_ls (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .in_valid    (bk_ls_wstart | bk_ls_rstart),
        .in_data     (ls_in),
        .in_ready    (bk_ls_ready),
        .out_valid   (ls_valid),
        .out_data    (ls_head),
        .out_ready   (ls_pop)
    );

    // a beat moves only when valid and ready are both high
    req_fifo #(.WIDTH($bits(rmt_beat_t)), .FIFO_DEPTH(FIFO_DEPTH)) fifo_ss (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .in_valid    (bk_ss_valid & bk_ss_ready),
        .in_data     (ss_in),
        .in_ready    (bk_ss_ready),
        .out_valid   (ss_valid),
        .out_data    (ss_head),
        .out_ready   (ss_pop)
    );

    stream_assembler u_asm (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .beat_valid  (ss_valid),
        .beat        (ss_head),
        .beat_pop    (ss_pop),
        .rmt_valid   (rmt_valid),
        .rmt         (rmt),
        .rmt_take    (rmt_take)
    );

    mbox_ctrl u_ctrl (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .ls_valid      (ls_valid),
        .ls_req        (ls_head),
        .ls_pop        (ls_pop),
        .rmt_valid     (rmt_valid),
        .rmt           (rmt),
        .rmt_take      (rmt_take),
        .reg_cmd_valid (reg_cmd_valid),
        .reg_cmd       (reg_cmd),
        .rd_data       (rd_data),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ls_rdone   (bk_ls_rdone),
        .irq_req       (irq_req)
    );

    mbox_regs u_regs (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .reg_cmd_valid (reg_cmd_valid),
        .reg_cmd       (reg_cmd),
        .irq_req       (irq_req),
        .rd_data       (rd_data),
        .axi_interrupt (axi_interrupt)
    );

endmodule

// ==== mbox/mbox_regs.sv ====
// Mailbox and attention registers
`timescale 1ns/10ps

module mbox_regs
    import mbox_pkg::*;
(
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  logic              reg_cmd_valid,
    input  reg_cmd_t          reg_cmd,
    input  logic              irq_req,
    output logic [DATA_W-1:0] rd_data,
    output logic              axi_interrupt
);

    logic [DATA_W-1:0] mb_q [MB_NUM];
    logic              irq_en;
    logic              irq_sts;
    logic              aa_sel_sts;

    assign aa_sel_sts = reg_cmd.idx[0];

    // ------------------------------------------------------------
    // register updates
    // ------------------------------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < MB_NUM; i++) begin
                mb_q[i] <= '0;
            end
            irq_en        <= 1'b0;
            irq_sts       <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            if (reg_cmd_valid && reg_cmd.op == OP_MB_WR) begin
                mb_q[reg_cmd.idx] <= reg_cmd.wdata;
            end
            if (reg_cmd_valid && reg_cmd.op == OP_AA_WR) begin
                if (!aa_sel_sts) begin
                    irq_en <= reg_cmd.wdata[0];
                end else if (reg_cmd.wdata[0]) begin
                    // status is write-one-to-clear
                    irq_sts <= 1'b0;
                end
            end
            // remote mailbox write, only when enabled
            axi_interrupt <= irq_req && irq_en;
            if (irq_req && irq_en) begin
                irq_sts <= 1'b1;
            end
        end
    end

    // read data, one cycle after the command
    always_ff @(posedge axi_aclk) begin
        if (reg_cmd_valid) begin
            case (reg_cmd.op)
                OP_MB_RD: rd_data <= mb_q[reg_cmd.idx];
                OP_AA_RD: rd_data <= {{(DATA_W-1){1'b0}}, aa_sel_sts ? irq_sts : irq_en};
                default:  rd_data <= rd_data;
            endcase
        end
    end

    // decoder only lets word offsets 0 and 4 through
    a_aa_index: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        reg_cmd_valid && (reg_cmd.op inside {OP_AA_WR, OP_AA_RD}) |-> reg_cmd.idx <= 1
    ) else $error("mbox_regs: attention index out of range");

    a_remote_mb_only: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        reg_cmd_valid && reg_cmd.remote |-> reg_cmd.op == OP_MB_WR
    ) else $error("mbox_regs: remote command other than mailbox write");

endmodule

// ==== mbox/mbox_ctrl.sv ====
// Mailbox request controller
`timescale 1ns/10ps

module mbox_ctrl
    import mbox_pkg::*;
(
    input  logic              axi_aclk,
    input  logic              axi_aresetn,
    input  logic              ls_valid,
    input  ls_req_t           ls_req,
    output logic              ls_pop,
    input  logic              rmt_valid,
    input  rmt_wr_t           rmt,
    output logic              rmt_take,
    output logic              reg_cmd_valid,
    output reg_cmd_t          reg_cmd,
    input  logic [DATA_W-1:0] rd_data,
    output logic [DATA_W-1:0] bk_ls_rdata,
    output logic              bk_ls_rdone,
    output logic              irq_req
);

    ctrl_state_e state;
    ctrl_state_e next_state;
    src_e        last_src;
    logic        pick_ss;
    logic        served;
    logic        cmd_is_rd;
    logic        cmd_is_rmt_wr;
    reg_cmd_t    cmd_next;

    // ------------------------------------------------------------
    // round robin and decode, used in DECIDE
    // ------------------------------------------------------------
    assign pick_ss = rmt_valid && (!ls_valid || last_src == SRC_LS);

    always_comb begin
        cmd_next        = '0;
        cmd_next.op     = OP_NONE;
        cmd_next.remote = pick_ss;
        if (pick_ss) begin
            // remote side may only write the mailbox
            cmd_next.idx   = rmt.addr[4:2];
            cmd_next.wdata = rmt.data;
            if (rmt.addr >= RMT_ADDR_W'(MB_LOW) && rmt.addr <= RMT_ADDR_W'(MB_HIGH)) begin
                cmd_next.op = OP_MB_WR;
            end
        end else begin
            cmd_next.idx   = ls_req.addr[4:2];
            cmd_next.wdata = ls_req.wdata;
            if (ls_req.addr >= MB_LOW && ls_req.addr <= MB_HIGH) begin
                cmd_next.op = (ls_req.op == LS_WR) ? OP_MB_WR : OP_MB_RD;
            end else if (ls_req.addr >= AA_LOW && ls_req.addr <= AA_HIGH) begin
                cmd_next.op = (ls_req.op == LS_WR) ? OP_AA_WR : OP_AA_RD;
            end else if (ls_req.op == LS_RD) begin
                cmd_next.op = OP_UNSUPP_RD;
            end
        end
    end

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    assign cmd_is_rd     = reg_cmd.op inside {OP_MB_RD, OP_AA_RD, OP_UNSUPP_RD};
    assign cmd_is_rmt_wr = reg_cmd.remote && (reg_cmd.op == OP_MB_WR);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (ls_valid || rmt_valid) next_state = DECIDE;
            DECIDE:  next_state = EXEC;
            EXEC: begin
                if (cmd_is_rd) begin
                    next_state = RESPOND;
                end else if (cmd_is_rmt_wr) begin
                    next_state = IRQ;
                end else begin
                    next_state = IDLE;
                end
            end
            RESPOND: next_state = IDLE;
            IRQ:     next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state         <= IDLE;
            last_src      <= SRC_SS;
            reg_cmd       <= '0;
            reg_cmd_valid <= 1'b0;
        end else begin
            state         <= next_state;
            reg_cmd_valid <= 1'b0;
            if (state == DECIDE) begin
                last_src      <= pick_ss ? SRC_SS : SRC_LS;
                reg_cmd       <= cmd_next;
                // nothing to tell the registers for a dropped request
                reg_cmd_valid <= (cmd_next.op != OP_NONE);
            end
        end
    end

    // served item leaves its queue on the way back to IDLE
    assign served   = (state != IDLE) && (next_state == IDLE);
    assign ls_pop   = served && (last_src == SRC_LS);
    assign rmt_take = served && (last_src == SRC_SS);

    assign irq_req = (state == IRQ);

    // register read data arrives in RESPOND
    assign bk_ls_rdone = (state == RESPOND);
    assign bk_ls_rdata = (reg_cmd.op == OP_UNSUPP_RD) ? UNSUPP_RDATA : rd_data;

    a_rdone_pulse: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        bk_ls_rdone |=> !bk_ls_rdone
    ) else $error("mbox_ctrl: rdone longer than one cycle");

endmodule

// ==== hdl/stream_assembler.sv ====
// Remote write assembler
`timescale 1ns/10ps

module stream_assembler
    import mbox_pkg::*;
(
    input  logic      axi_aclk,
    input  logic      axi_aresetn,
    input  logic      beat_valid,
    input  rmt_beat_t beat,
    output logic      beat_pop,
    output logic      rmt_valid,
    output rmt_wr_t   rmt,
    input  logic      rmt_take
);

    logic                  have_addr;
    logic [RMT_ADDR_W-1:0] addr_q;
    logic                  wr_beat;

    // no pops while a finished write waits for the controller
    assign beat_pop = beat_valid && (!rmt_valid || rmt_take);
    assign wr_beat  = beat_pop && (beat.user == RMT_USER_WR);

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            have_addr <= 1'b0;
            rmt_valid <= 1'b0;
        end else begin
            if (rmt_take) begin
                rmt_valid <= 1'b0;
            end
            // other tuser values fall through and are dropped
            if (wr_beat) begin
                have_addr <= !have_addr;
                if (have_addr) begin
                    rmt_valid <= 1'b1;
                end
            end
        end
    end

    // address beat, then data beat completes the pair
    always_ff @(posedge axi_aclk) begin
        if (wr_beat && !have_addr) begin
            addr_q <= beat.data[RMT_ADDR_W-1:0];
        end
        if (wr_beat && have_addr) begin
            rmt.addr <= addr_q;
            rmt.data <= beat.data;
        end
    end

    a_rmt_stable: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        rmt_valid && !rmt_take |=> $stable(rmt)
    ) else $error("stream_assembler: rmt changed while waiting");

endmodule

// ==== hdl/req_fifo.sv ====
// Synchronous request FIFO
`timescale 1ns/10ps

module req_fifo #(
    parameter int WIDTH      = 32,
    parameter int FIFO_DEPTH = 8
) (
    input  logic             axi_aclk,
    input  logic             axi_aresetn,
    input  logic             in_valid,
    input  logic [WIDTH-1:0] in_data,
    output logic             in_ready,
    output logic             out_valid,
    output logic [WIDTH-1:0] out_data,
    input  logic             out_ready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != FIFO_DEPTH[PTR_W:0]);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // full FIFO drops the push
    assign push = in_valid && in_ready;
    assign pop  = out_ready && out_valid;

    // storage
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer must hold off while the FIFO is full
    a_no_push_when_full: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        in_valid |-> in_ready
    ) else $error("req_fifo: push while full");

endmodule

// ==== common/mbox_pkg.sv ====
// Mailbox bridge definitions
package mbox_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int ADDR_W     = 15;
    localparam int DATA_W     = 32;
    localparam int MB_NUM     = 8;
    localparam int MB_IDX_W   = 3;
    localparam int RMT_ADDR_W = 28;

    // ------------------------------------------------------------
    // address map
    // ------------------------------------------------------------
    localparam logic [ADDR_W-1:0] MB_LOW  = 15'h2000;
    localparam logic [ADDR_W-1:0] MB_HIGH = 15'h201F;
    localparam logic [ADDR_W-1:0] AA_LOW  = 15'h2100;
    localparam logic [ADDR_W-1:0] AA_HIGH = 15'h2107;

    // answer for reads outside the register map
    localparam logic [DATA_W-1:0] UNSUPP_RDATA = 32'hFFFF_FFFF;

    // tuser code of a two-beat remote write
    localparam logic [1:0] RMT_USER_WR = 2'b01;

    // ------------------------------------------------------------
    // enums
    // ------------------------------------------------------------
    typedef enum logic {LS_WR, LS_RD} ls_op_e;

    typedef enum logic [2:0] {IDLE, DECIDE, EXEC, RESPOND, IRQ} ctrl_state_e;

    typedef enum logic {SRC_LS, SRC_SS} src_e;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_MB_WR,
        OP_MB_RD,
        OP_AA_WR,
        OP_AA_RD,
        OP_UNSUPP_RD
    } reg_op_e;

    // ------------------------------------------------------------
    // structs
    // ------------------------------------------------------------
    // local request, 48 bits
    typedef struct packed {
        ls_op_e            op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } ls_req_t;

    // one stream beat, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        user;
    } rmt_beat_t;

    // assembled remote write, 60 bits
    typedef struct packed {
        logic [RMT_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } rmt_wr_t;

    typedef struct packed {
        reg_op_e             op;
        logic [MB_IDX_W-1:0] idx;
        logic [DATA_W-1:0]   wdata;
        logic                remote;
    } reg_cmd_t;

endpackage
